// ==== bench/dcache_checker.sv ====
`timescale 1ns/1ps

module dcache_checker
    import cache_pkg::*;
(
    input logic       CLK,
    input logic       nRST,
    input dp_req_t    dp_req,
    input logic       halt,
    input logic       dhit,
    input logic       flushed,
    input snoop_req_t snoop,
    input logic       ccwrite
);

    int   fails = 0;
    logic req;

    assign req = dp_req.ren || dp_req.wen;

    assert property (@(posedge CLK) disable iff (!nRST) !(dhit && flushed))
        else begin
            $error("dhit and flushed are high in the same cycle");
            fails++;
        end

    // Dirty data goes out only while the snoop is held
    assert property (@(posedge CLK) disable iff (!nRST) ccwrite |-> snoop.ccwait)
        else begin
            $error("ccwrite is high without a snoop");
            fails++;
        end

    assert property (@(posedge CLK) disable iff (!nRST) flushed |-> halt)
        else begin
            $error("flushed is high while halt is low");
            fails++;
        end

    // A block that just hit must hit at once on the next request
    assert property (@(posedge CLK) disable iff (!nRST)
        req && !snoop.ccwait && !halt && $past(dhit)
            && dp_req.addr.tag == $past(dp_req.addr.tag)
            && dp_req.addr.idx == $past(dp_req.addr.idx)
        |-> dhit)
        else begin
            $error("request to a resident block did not hit in its own cycle");
            fails++;
        end

endmodule

bind dcache_system dcache_checker chk (
    .CLK     (CLK),
    .nRST    (nRST),
    .dp_req  (dp_req),
    .halt    (halt),
    .dhit    (dhit),
    .flushed (flushed),
    .snoop   (snoop),
    .ccwrite (ccwrite)
);

// ==== bench/dcache_monitor.sv ====
`timescale 1ns/1ps

module dcache_monitor
    import cache_pkg::*;
#(
    parameter int    MEM_WORDS      = 4096,
    parameter word_t HIT_COUNT_ADDR = 32'h0000_3100
) (
    input  logic       CLK,
    input  logic       nRST,
    input  dp_req_t    dp_req,
    input  logic       dhit,
    input  word_t      dmemload,
    input  logic       flushed,
    input  snoop_req_t snoop,
    input  logic       ccwrite,
    input  word_t      snoop_data,
    output int         checks,
    output int         errors
);

    // Words written to memory so far by word index
    word_t shadow [int];

    // Reference copy of the cache contents
    logic              m_valid [NUM_WAYS][NUM_SETS];
    logic              m_dirty [NUM_WAYS][NUM_SETS];
    logic [DTAG_W-1:0] m_tag   [NUM_WAYS][NUM_SETS];
    word_t             m_data  [NUM_WAYS][NUM_SETS][2];
    logic              m_lru;
    word_t             m_hits;
    logic              flush_seen;

    function automatic int word_index(input word_t a);
        return int'((a >> 2) % MEM_WORDS);
    endfunction

    function automatic word_t mem_word(input word_t a);
        if (shadow.exists(word_index(a))) begin
            return shadow[word_index(a)];
        end
        return word_t'(word_index(a)) ^ 32'hA5A5_0000;
    endfunction

    function automatic word_t word_addr(
        input logic [DTAG_W-1:0] tag,
        input logic [DIDX_W-1:0] set,
        input logic              blk
    );
        return {tag, set, blk, 2'b00};
    endfunction

    // Way 0 is searched first and a miss returns the LRU way
    function automatic logic lookup(
        input  logic [DTAG_W-1:0] tag,
        input  logic [DIDX_W-1:0] set,
        output logic              way
    );
        logic hit;
        hit = 1'b0;
        way = m_lru;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (!hit && m_valid[w][set] && m_tag[w][set] == tag) begin
                hit = 1'b1;
                way = 1'(w);
            end
        end
        return hit;
    endfunction

    task automatic compare(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic write_back(input logic way, input logic [DIDX_W-1:0] set);
        for (int b = 0; b < 2; b++) begin
            shadow[word_index(word_addr(m_tag[way][set], set, 1'(b)))] = m_data[way][set][b];
        end
        m_dirty[way][set] = 1'b0;
    endtask

    task automatic track_access();
        logic     way;
        dcachef_t a;
        a = dp_req.addr;
        if (lookup(a.tag, a.idx, way)) begin
            m_hits++;
        end else begin
            if (m_valid[way][a.idx] && m_dirty[way][a.idx]) begin
                write_back(way, a.idx);
            end
            for (int b = 0; b < 2; b++) begin
                m_data[way][a.idx][b] = mem_word(word_addr(a.tag, a.idx, 1'(b)));
            end
            m_tag[way][a.idx]   = a.tag;
            m_valid[way][a.idx] = 1'b1;
            m_dirty[way][a.idx] = 1'b0;
            m_lru = !m_lru;
        end
        if (dp_req.wen) begin
            m_data[way][a.idx][a.blkoff] = dp_req.store;
            m_dirty[way][a.idx] = 1'b1;
        end
        compare("dmemload", dmemload, m_data[way][a.idx][a.blkoff]);
    endtask

    task automatic check_snoop();
        logic              way;
        logic              hit;
        logic              supply;
        logic [DIDX_W-1:0] set;
        set    = snoop.addr.idx;
        hit    = lookup(snoop.addr.tag, set, way);
        supply = !snoop.ccinv && hit && m_dirty[way][set];
        compare("ccwrite", word_t'(ccwrite), word_t'(supply));
        if (supply) begin
            compare("snoop_data", snoop_data, m_data[way][set][snoop.addr.blkoff]);
            m_dirty[way][set] = 1'b0;
        end else if (snoop.ccinv && hit) begin
            m_valid[way][set] = 1'b0;
            m_dirty[way][set] = 1'b0;
        end
    endtask

    task automatic record_flush();
        for (int w = 0; w < NUM_WAYS; w++) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                if (m_valid[w][s] && m_dirty[w][s]) begin
                    write_back(1'(w), DIDX_W'(s));
                end
            end
        end
        shadow[word_index(HIT_COUNT_ADDR)] = m_hits;
    endtask

    // Outputs are settled by the falling edge
    always @(negedge CLK) begin
        if (!nRST) begin
            shadow.delete();
            m_valid    = '{default: '0};
            m_dirty    = '{default: '0};
            m_lru      = 1'b0;
            m_hits     = '0;
            flush_seen = 1'b0;
            checks     = 0;
            errors     = 0;
        end else begin
            if (snoop.ccwait) begin
                check_snoop();
            end else if (dhit) begin
                track_access();
            end
            if (flushed && !flush_seen) begin
                record_flush();
            end
            flush_seen = flushed;
        end
    end

endmodule

// ==== bench/dcache_system_tb.sv ====
`timescale 1ns/1ps

module dcache_system_tb
    import cache_pkg::*;
();

    localparam int    MEM_LATENCY    = 2;
    localparam word_t HIT_COUNT_ADDR = 32'h0000_3100;
    localparam int    RESET_CYCLES   = 10;
    localparam int    WAIT_LIMIT     = 400;
    localparam int    CLEAN_MISS     = 2 * (MEM_LATENCY + 1) + 1;
    localparam int    DIRTY_MISS     = CLEAN_MISS + 2 * (MEM_LATENCY + 1);

    typedef enum int {OP_RD, OP_WR, OP_SNR, OP_SNI, OP_HALT} op_e;

    // exp is cycles to dhit for an access (-1 skips) or ccwrite for a snoop read
    typedef struct {
        op_e   op;
        word_t addr;
        int    exp;
    } step_t;

    logic        CLK;
    logic        nRST;
    dp_req_t     dp_req;
    logic        halt;
    snoop_req_t  snoop;
    logic        dhit;
    word_t       dmemload;
    logic        flushed;
    logic        ccwrite;
    word_t       snoop_data;

    step_t       steps[$];
    logic [31:0] lfsr;
    int          timeouts;
    int          tb_errors;
    int          mon_checks;
    int          mon_errors;

    tb_clock #(.PERIOD_NS(40)) u_clock (.CLK(CLK));

    dcache_system #(
        .MEM_LATENCY    (MEM_LATENCY),
        .MEM_WORDS      (4096),
        .HIT_COUNT_ADDR (HIT_COUNT_ADDR)
    ) uut (
        .CLK        (CLK),
        .nRST       (nRST),
        .dp_req     (dp_req),
        .halt       (halt),
        .dhit       (dhit),
        .dmemload   (dmemload),
        .flushed    (flushed),
        .snoop      (snoop),
        .ccwrite    (ccwrite),
        .snoop_data (snoop_data)
    );

    dcache_monitor #(
        .MEM_WORDS      (4096),
        .HIT_COUNT_ADDR (HIT_COUNT_ADDR)
    ) u_monitor (
        .CLK        (CLK),
        .nRST       (nRST),
        .dp_req     (dp_req),
        .dhit       (dhit),
        .dmemload   (dmemload),
        .flushed    (flushed),
        .snoop      (snoop),
        .ccwrite    (ccwrite),
        .snoop_data (snoop_data),
        .checks     (mon_checks),
        .errors     (mon_errors)
    );

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic word_t take_bits(input int n);
        word_t v;
        logic  fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic word_t word_addr(input int tag, input int set, input int blk);
        dcachef_t a;
        a.tag    = DTAG_W'(tag);
        a.idx    = DIDX_W'(set);
        a.blkoff = DBLK_W'(blk);
        a.bytoff = '0;
        return a;
    endfunction

    task automatic add_step(input op_e op, input word_t addr, input int exp);
        step_t s;
        s.op   = op;
        s.addr = addr;
        s.exp  = exp;
        steps.push_back(s);
    endtask

    task automatic build_table();
        op_e op;
        int  tag;
        int  set;
        int  blk;
        // Read miss then hits and writes on the same block
        add_step(OP_RD, word_addr(1, 2, 0), CLEAN_MISS);
        add_step(OP_RD, word_addr(1, 2, 0), 0);
        add_step(OP_WR, word_addr(1, 2, 1), 0);
        add_step(OP_RD, word_addr(1, 2, 1), 0);
        add_step(OP_WR, word_addr(1, 2, 0), 0);
        // Three tags in set 2 where dirty tag 1 is evicted and read back
        add_step(OP_RD, word_addr(2, 2, 0), CLEAN_MISS);
        add_step(OP_RD, word_addr(3, 2, 0), DIRTY_MISS);
        add_step(OP_RD, word_addr(1, 2, 0), CLEAN_MISS);
        // Snoop reads on a dirty, a now clean and an absent line
        add_step(OP_WR, word_addr(5, 4, 1), CLEAN_MISS);
        add_step(OP_SNR, word_addr(5, 4, 1), 1);
        add_step(OP_SNR, word_addr(5, 4, 1), 0);
        add_step(OP_SNR, word_addr(6, 4, 0), 0);
        // Invalidated dirty line so the read sees old memory
        add_step(OP_WR, word_addr(7, 5, 0), CLEAN_MISS);
        add_step(OP_SNI, word_addr(7, 5, 0), 0);
        add_step(OP_RD, word_addr(7, 5, 0), CLEAN_MISS);
        // Dirty block left for the flush
        add_step(OP_WR, word_addr(9, 6, 0), CLEAN_MISS);
        add_step(OP_WR, word_addr(9, 6, 1), 0);
        // Random blocks in sets 0 to 3 with tags 16 to 31
        for (int i = 0; i < 8; i++) begin
            op  = take_bits(1) ? OP_WR : OP_RD;
            tag = 16 + int'(take_bits(4));
            set = int'(take_bits(2));
            blk = int'(take_bits(1));
            add_step(op, word_addr(tag, set, blk), -1);
        end
        add_step(OP_HALT, '0, -1);
        // Flushed data and the stored hit count come back from memory
        add_step(OP_SNI, word_addr(9, 6, 0), 0);
        add_step(OP_RD, word_addr(9, 6, 0), CLEAN_MISS);
        add_step(OP_RD, word_addr(9, 6, 1), 0);
        add_step(OP_SNI, HIT_COUNT_ADDR, 0);
        add_step(OP_RD, HIT_COUNT_ADDR, CLEAN_MISS);
    endtask

    task automatic access_block(input step_t s);
        int n;
        dp_req.ren  = (s.op == OP_RD);
        dp_req.wen  = (s.op == OP_WR);
        dp_req.addr = s.addr;
        if (s.op == OP_WR) begin
            dp_req.store = take_bits(32);
        end
        n = 0;
        @(negedge CLK);
        while (!dhit && n < WAIT_LIMIT) begin
            @(negedge CLK);
            n++;
        end
        if (!dhit) begin
            timeouts++;
            $display("Timeout: no dhit for address %h after %0d cycles", s.addr, n);
        end else if (s.exp >= 0 && n != s.exp) begin
            tb_errors++;
            $display("FAILED dhit latency at %h: got %h expected %h", s.addr, n, s.exp);
        end
        @(posedge CLK);
        #1;
        dp_req = '0;
    endtask

    task automatic snoop_block(input step_t s);
        snoop.ccwait = 1'b1;
        snoop.ccinv  = (s.op == OP_SNI);
        snoop.addr   = s.addr;
        @(negedge CLK);
        if (s.op == OP_SNR && ccwrite !== 1'(s.exp)) begin
            tb_errors++;
            $display("FAILED ccwrite at %h: got %h expected %h", s.addr, ccwrite, s.exp);
        end
        @(posedge CLK);
        #1;
        snoop = '0;
    endtask

    task automatic halt_and_flush();
        int n;
        halt = 1'b1;
        n = 0;
        @(negedge CLK);
        while (!flushed && n < WAIT_LIMIT) begin
            @(negedge CLK);
            n++;
        end
        if (!flushed) begin
            timeouts++;
            $display("Timeout: flushed did not rise within %0d cycles of halt", n);
        end
        @(posedge CLK);
        #1;
        halt = 1'b0;
        // One cycle for the cache to leave FLUSH_DONE
        @(posedge CLK);
        #1;
    endtask

    initial begin
        lfsr      = 32'd88385;
        timeouts  = 0;
        tb_errors = 0;
        nRST      = 1'b0;
        dp_req    = '0;
        halt      = 1'b0;
        snoop     = '0;
        build_table();
        repeat (RESET_CYCLES) @(posedge CLK);
        #1;
        nRST = 1'b1;
        @(posedge CLK);
        #1;
        foreach (steps[i]) begin
            case (steps[i].op)
                OP_RD, OP_WR: access_block(steps[i]);
                OP_SNR, OP_SNI: snoop_block(steps[i]);
                default: halt_and_flush();
            endcase
        end
        repeat (2) @(posedge CLK);
        $display("Checks %0d, errors: monitor %0d bench %0d assertion %0d, timeouts %0d",
                 mon_checks, mon_errors, tb_errors, uut.chk.fails, timeouts);
        if (mon_errors == 0 && tb_errors == 0 && uut.chk.fails == 0 && timeouts == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== bench/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 40
) (
    output logic CLK
);

    initial begin
        CLK = 1'b0;
        forever begin
            #(PERIOD_NS / 2) CLK = ~CLK;
        end
    end

endmodule

// ==== dcache_system.f ====
verilog/cache_pkg.sv
verilog/main_memory.sv
verilog/dcache.sv
verilog/dcache_system.sv
bench/tb_clock.sv
bench/dcache_monitor.sv
bench/dcache_checker.sv
bench/dcache_system_tb.sv

// ==== verilog/cache_pkg.sv ====
package cache_pkg;

    // Basic data word
    typedef logic [31:0] word_t;

    // Address split widths
    localparam int DTAG_W = 26;
    localparam int DIDX_W = 3;
    localparam int DBLK_W = 1;
    localparam int DBYT_W = 2;

    // Cache geometry
    localparam int NUM_WAYS = 2;
    localparam int NUM_SETS = 8;

    // Byte address as seen by the cache
    typedef struct packed {
        logic [DTAG_W-1:0] tag;
        logic [DIDX_W-1:0] idx;
        logic [DBLK_W-1:0] blkoff;
        logic [DBYT_W-1:0] bytoff;
    } dcachef_t;

    // One cache frame of 92 bits
    typedef struct packed {
        logic                      valid;
        logic                      dirty;
        logic [DTAG_W-1:0]         tag;
        word_t [2**DBLK_W-1:0]     data;
    } dcache_frame_t;

    // Datapath request with levels held until dhit
    typedef struct packed {
        logic     ren;
        logic     wen;
        dcachef_t addr;
        word_t    store;
    } dp_req_t;

    // Cache to memory request by byte address
    typedef struct packed {
        logic  ren;
        logic  wen;
        word_t addr;
        word_t store;
    } mem_req_t;

    // Coherence snoop request
    typedef struct packed {
        logic     ccwait;
        logic     ccinv;
        dcachef_t addr;
    } snoop_req_t;

    typedef enum logic [3:0] {
        COMPARE_TAG,
        WRITE_BACK1,
        WRITE_BACK2,
        ALLOCATE1,
        ALLOCATE2,
        FLUSH_SCAN,
        FLUSH_WORD0,
        FLUSH_WORD1,
        FLUSH_COUNT,
        FLUSH_DONE
    } dcache_state_e;

endpackage

// ==== verilog/dcache.sv ====
`timescale 1ns/1ps

module dcache
    import cache_pkg::*;
#(
    parameter word_t HIT_COUNT_ADDR = 32'h0000_3100
) (
    input  logic       CLK,
    input  logic       nRST,

    // Datapath side
    input  dp_req_t    dp_req,
    input  logic       halt,
    output logic       dhit,
    output word_t      dmemload,
    output logic       flushed,

    // Snoop side
    input  snoop_req_t snoop,
    output logic       ccwrite,
    output word_t      snoop_data,

    // Memory side
    output mem_req_t   mem_req,
    input  logic       dwait,
    input  word_t      dload
);

    dcache_state_e state, next_state;

    dcache_frame_t [NUM_WAYS-1:0][NUM_SETS-1:0] frames, next_frames;

    logic              lru, next_lru;
    logic [DIDX_W:0]   flush_idx, next_flush_idx;
    word_t             hit_count, next_hit_count;
    logic              miss_done, next_miss_done;

    // Lookup results
    logic              dp_hit;
    logic              dp_way;
    logic              sn_hit;
    logic              sn_way;

    logic [DIDX_W-1:0] req_set;
    logic [DIDX_W-1:0] sn_set;
    logic              flush_way;
    logic [DIDX_W-1:0] flush_set;
    logic              flush_last;
    dcache_frame_t     victim;
    dcache_frame_t     fl_frame;

    // Block-aligned byte address of one word
    function automatic word_t blk_addr(
        input logic [DTAG_W-1:0] tag,
        input logic [DIDX_W-1:0] set,
        input logic [DBLK_W-1:0] blk
    );
        dcachef_t a;
        a.tag    = tag;
        a.idx    = set;
        a.blkoff = blk;
        a.bytoff = '0;
        return a;
    endfunction

    assign req_set = dp_req.addr.idx;
    assign sn_set  = snoop.addr.idx;

    // Flush index walks way 0 then way 1
    assign flush_way  = flush_idx[DIDX_W];
    assign flush_set  = flush_idx[DIDX_W-1:0];
    assign flush_last = &flush_idx;

    assign victim   = frames[lru][req_set];
    assign fl_frame = frames[flush_way][flush_set];

    // Tag compare in both ways where way 0 wins a tie
    always_comb begin
        dp_hit = 1'b0;
        dp_way = 1'b0;
        sn_hit = 1'b0;
        sn_way = 1'b0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (frames[w][req_set].valid && frames[w][req_set].tag == dp_req.addr.tag) begin
                dp_hit = 1'b1;
                dp_way = 1'(w);
            end
            if (frames[w][sn_set].valid && frames[w][sn_set].tag == snoop.addr.tag) begin
                sn_hit = 1'b1;
                sn_way = 1'(w);
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= COMPARE_TAG;
            frames    <= '0;
            lru       <= 1'b0;
            flush_idx <= '0;
            hit_count <= '0;
            miss_done <= 1'b0;
        end else begin
            state     <= next_state;
            frames    <= next_frames;
            lru       <= next_lru;
            flush_idx <= next_flush_idx;
            hit_count <= next_hit_count;
            miss_done <= next_miss_done;
        end
    end

    always_comb begin
        next_state     = state;
        next_frames    = frames;
        next_lru       = lru;
        next_flush_idx = flush_idx;
        next_hit_count = hit_count;
        next_miss_done = miss_done;

        dhit       = 1'b0;
        dmemload   = '0;
        flushed    = 1'b0;
        ccwrite    = 1'b0;
        snoop_data = '0;
        mem_req    = '0;

        case (state)
            COMPARE_TAG: begin
                if (snoop.ccwait) begin
                    // Snoops go ahead of the datapath
                    if (sn_hit && snoop.ccinv) begin
                        next_frames[sn_way][sn_set].valid = 1'b0;
                        next_frames[sn_way][sn_set].dirty = 1'b0;
                    end else if (sn_hit && frames[sn_way][sn_set].dirty) begin
                        // Modified line hands its word to the bus
                        ccwrite    = 1'b1;
                        snoop_data = frames[sn_way][sn_set].data[snoop.addr.blkoff];
                        next_frames[sn_way][sn_set].dirty = 1'b0;
                    end
                end else if (halt) begin
                    next_state     = FLUSH_SCAN;
                    next_flush_idx = '0;
                end else if (dp_req.ren || dp_req.wen) begin
                    if (dp_hit) begin
                        dhit     = 1'b1;
                        dmemload = frames[dp_way][req_set].data[dp_req.addr.blkoff];

                        // The hit that ends a miss is not counted
                        if (miss_done) begin
                            next_miss_done = 1'b0;
                        end else begin
                            next_hit_count = hit_count + 1'b1;
                        end

                        if (dp_req.wen) begin
                            dmemload = dp_req.store;
                            next_frames[dp_way][req_set].data[dp_req.addr.blkoff] = dp_req.store;
                            next_frames[dp_way][req_set].dirty = 1'b1;
                        end
                    end else if (victim.dirty) begin
                        next_state = WRITE_BACK1;
                    end else begin
                        next_state = ALLOCATE1;
                    end
                end
            end

            WRITE_BACK1: begin
                mem_req.wen   = 1'b1;
                mem_req.addr  = blk_addr(victim.tag, req_set, 1'b0);
                mem_req.store = victim.data[0];
                if (!dwait) begin
                    next_state = WRITE_BACK2;
                end
            end

            WRITE_BACK2: begin
                mem_req.wen   = 1'b1;
                mem_req.addr  = blk_addr(victim.tag, req_set, 1'b1);
                mem_req.store = victim.data[1];
                if (!dwait) begin
                    next_state = ALLOCATE1;
                end
            end

            ALLOCATE1: begin
                mem_req.ren  = 1'b1;
                mem_req.addr = blk_addr(dp_req.addr.tag, req_set, 1'b0);
                if (!dwait) begin
                    next_frames[lru][req_set].data[0] = dload;
                    next_state = ALLOCATE2;
                end
            end

            ALLOCATE2: begin
                mem_req.ren  = 1'b1;
                mem_req.addr = blk_addr(dp_req.addr.tag, req_set, 1'b1);
                if (!dwait) begin
                    next_frames[lru][req_set].data[1] = dload;
                    next_frames[lru][req_set].tag     = dp_req.addr.tag;
                    next_frames[lru][req_set].valid   = 1'b1;
                    next_frames[lru][req_set].dirty   = 1'b0;
                    next_lru       = !lru;
                    next_miss_done = 1'b1;
                    next_state     = COMPARE_TAG;
                end
            end

            FLUSH_SCAN: begin
                if (fl_frame.valid && fl_frame.dirty) begin
                    next_state = FLUSH_WORD0;
                end else if (flush_last) begin
                    next_state = FLUSH_COUNT;
                end else begin
                    next_flush_idx = flush_idx + 1'b1;
                end
            end

            FLUSH_WORD0: begin
                mem_req.wen   = 1'b1;
                mem_req.addr  = blk_addr(fl_frame.tag, flush_set, 1'b0);
                mem_req.store = fl_frame.data[0];
                if (!dwait) begin
                    next_state = FLUSH_WORD1;
                end
            end

            FLUSH_WORD1: begin
                mem_req.wen   = 1'b1;
                mem_req.addr  = blk_addr(fl_frame.tag, flush_set, 1'b1);
                mem_req.store = fl_frame.data[1];
                if (!dwait) begin
                    // Block is now clean in memory
                    next_frames[flush_way][flush_set].dirty = 1'b0;
                    if (flush_last) begin
                        next_state = FLUSH_COUNT;
                    end else begin
                        next_flush_idx = flush_idx + 1'b1;
                        next_state     = FLUSH_SCAN;
                    end
                end
            end

            FLUSH_COUNT: begin
                mem_req.wen   = 1'b1;
                mem_req.addr  = HIT_COUNT_ADDR;
                mem_req.store = hit_count;
                if (!dwait) begin
                    next_state = FLUSH_DONE;
                end
            end

            FLUSH_DONE: begin
                // Wait here until halt is dropped
                flushed = halt;
                if (!halt) begin
                    next_flush_idx = '0;
                    next_state     = COMPARE_TAG;
                end
            end

            default: begin
                next_state = COMPARE_TAG;
            end
        endcase
    end

endmodule

// ==== verilog/dcache_system.sv ====
`timescale 1ns/1ps

module dcache_system
    import cache_pkg::*;
#(
    parameter int    MEM_LATENCY    = 2,
    parameter int    MEM_WORDS      = 4096,
    parameter word_t HIT_COUNT_ADDR = 32'h0000_3100
) (
    input  logic       CLK,
    input  logic       nRST,

    // Datapath
    input  dp_req_t    dp_req,
    input  logic       halt,
    output logic       dhit,
    output word_t      dmemload,
    output logic       flushed,

    // Coherence bus stand-in
    input  snoop_req_t snoop,
    output logic       ccwrite,
    output word_t      snoop_data
);

    // Cache to memory link
    mem_req_t mem_req;
    logic     dwait;
    word_t    dload;

    dcache #(
        .HIT_COUNT_ADDR (HIT_COUNT_ADDR)
    ) u_dcache (
        .CLK        (CLK),
        .nRST       (nRST),
        .dp_req     (dp_req),
        .halt       (halt),
        .dhit       (dhit),
        .dmemload   (dmemload),
        .flushed    (flushed),
        .snoop      (snoop),
        .ccwrite    (ccwrite),
        .snoop_data (snoop_data),
        .mem_req    (mem_req),
        .dwait      (dwait),
        .dload      (dload)
    );

    main_memory #(
        .MEM_LATENCY (MEM_LATENCY),
        .MEM_WORDS   (MEM_WORDS)
    ) u_main_memory (
        .CLK     (CLK),
        .nRST    (nRST),
        .mem_req (mem_req),
        .dwait   (dwait),
        .dload   (dload)
    );

endmodule

// ==== verilog/main_memory.sv ====
`timescale 1ns/1ps

module main_memory
    import cache_pkg::*;
#(
    parameter int MEM_LATENCY = 2,
    parameter int MEM_WORDS   = 4096
) (
    input  logic     CLK,
    input  logic     nRST,
    input  mem_req_t mem_req,
    output logic     dwait,
    output word_t    dload
);

    localparam int AW    = $clog2(MEM_WORDS);
    localparam int CNT_W = $clog2(MEM_LATENCY + 2);

    // Word array indexed by byte address bits [AW+1:2]
    word_t mem [MEM_WORDS];

    logic [CNT_W-1:0] wait_cnt;
    logic             active;
    logic             done;
    logic [AW-1:0]    word_idx;

    assign active   = mem_req.ren || mem_req.wen;
    assign word_idx = mem_req.addr[AW+1:2];

    // Access completes after MEM_LATENCY stalled cycles
    assign done  = active && (wait_cnt == CNT_W'(MEM_LATENCY));
    assign dwait = !done;

    // Upper address bits wrap onto the array
    assign dload = mem[word_idx];

    // Wait-state counter
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wait_cnt <= '0;
        end else if (!active || done) begin
            // Idle or finished so the next word pays full latency again
            wait_cnt <= '0;
        end else begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    // Contents at reset are word address XOR A5A50000
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= word_t'(i) ^ 32'hA5A5_0000;
            end
        end else if (mem_req.wen && done) begin
            mem[word_idx] <= mem_req.store;
        end
    end

endmodule
